// File: Makefile
simulate:
	verilator --binary --timescale 1ns/100ps -Wno-fatal -f controlUnit.f \
		--top-module tbControlUnit -o simControlUnit
	./obj_dir/simControlUnit | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

// File: branchEval.sv
`timescale 1ns/100ps
`default_nettype none

module branchEval
	import ctrlPkg::*;
	(
	input wire logic EQ,
	input wire logic GT,
	instrInfoIf.evaluator info
);

	// comparator flags come from the ALU compare done in Compare
	always_comb begin
		case (info.branchKind)
			kindBeq: info.branchTaken = EQ;
			kindBne: info.branchTaken = !EQ;
			kindBle: info.branchTaken = !GT;
			kindBgt: info.branchTaken = GT;
			default: info.branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: controlSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module controlSequencer
	import ctrlPkg::*;
	(
	input wire logic clk,
	input wire logic reset,
	input wire logic Overflow,
	instrInfoIf.sequencer info,
	output logic [srcAddrWidth-1:0] SrcAddressMem,
	output logic MemOp,
	output logic WriteMDR,
	output logic IRWrite,
	output logic [regDstWidth-1:0] RegDst,
	output logic RegWrite,
	output logic WriteA,
	output logic WriteB,
	output logic [aluSrcAWidth-1:0] ALUSrcA,
	output logic [aluSrcBWidth-1:0] ALUSrcB,
	output logic [aluOpWidth-1:0] ALUOp,
	output logic WriteALUOut,
	output logic EPCWrite,
	output logic [pcSourceWidth-1:0] PCSource,
	output logic PCWrite,
	output logic [memToRegWidth-1:0] MemToReg
);

	logic [stateWidth-1:0] state;
	logic [stateWidth-1:0] nextState;
	logic [classWidth-1:0] heldClass; // captured in Decode
	logic [aluOpWidth-1:0] heldAluOp;
	logic [aluSrcBWidth-1:0] heldAluSrcB;
	logic ovfChecked;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= stReset;
			heldClass <= clsIllegal;
			heldAluOp <= aluPass;
			heldAluSrcB <= srcBReg;
		end else begin
			state <= nextState;
			if (state == stDecode) begin
				heldClass <= info.instrClass;
				heldAluOp <= info.execAluOp;
				heldAluSrcB <= info.execAluSrcB;
			end
		end
	end

	// and, slt and jr never trap
	assign ovfChecked = (heldClass == clsAluImm) ||
		((heldClass == clsAluR) && (heldAluOp == aluAdd || heldAluOp == aluSub));

	always_comb begin
		nextState = stFetch;
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stWait;
			stWait: nextState = stIrWrite;
			stIrWrite: nextState = stDecode;
			stDecode: begin
				case (info.instrClass)
					clsAluR, clsAluImm, clsSlt, clsJr: nextState = stExecute;
					clsJump: nextState = stJump;
					clsJal: nextState = stJalLink;
					clsBranch: nextState = stCompare;
					clsBreak: nextState = stBreak;
					clsRte: nextState = stRte;
					default: nextState = stFetch; // unknown code
				endcase
			end
			stExecute: begin
				if (ovfChecked && Overflow)
					nextState = stOvfExc;
				else if (heldClass == clsAluR)
					nextState = stWriteRd;
				else if (heldClass == clsAluImm)
					nextState = stWriteImm;
				else if (heldClass == clsSlt)
					nextState = stWriteSlt;
				else
					nextState = stFetch; // jr done
			end
			stCompare: nextState = info.branchTaken ? stBranch : stFetch;
			stJalLink: nextState = stJalWait1;
			stJalWait1: nextState = stJalWait2;
			stJalWait2: nextState = stJalWriteRa;
			stJalWriteRa: nextState = stJump;
			stOvfExc: nextState = stCause;
			stCause: nextState = stWriteCause;
			default: nextState = stFetch;
		endcase
	end

	always_comb begin
		SrcAddressMem = '0;
		MemOp = 1'b0;
		WriteMDR = 1'b0;
		IRWrite = 1'b0;
		RegDst = '0;
		RegWrite = 1'b0;
		WriteA = 1'b0;
		WriteB = 1'b0;
		ALUSrcA = '0;
		ALUSrcB = srcBReg;
		ALUOp = aluPass;
		WriteALUOut = 1'b0;
		EPCWrite = 1'b0;
		PCSource = '0;
		PCWrite = 1'b0;
		MemToReg = '0;

		case (state)
			stReset: begin
				RegWrite = 1'b1; // stack pointer load
				RegDst = regDstSp;
				MemToReg = memToRegSpInit;
			end
			stFetch: begin
				WriteMDR = 1'b1;
				ALUSrcB = srcBFour;
				ALUOp = aluAdd; // PC + 4
				PCWrite = 1'b1;
			end
			stIrWrite: IRWrite = 1'b1;
			stDecode: begin
				WriteA = 1'b1;
				WriteB = 1'b1;
				ALUSrcB = srcBShiftImm; // branch target ahead of time
				ALUOp = aluAdd;
				WriteALUOut = 1'b1;
			end
			stExecute: begin
				ALUSrcA = srcARegA;
				ALUSrcB = heldAluSrcB;
				ALUOp = heldAluOp;
				WriteALUOut = 1'b1;
				PCWrite = (heldClass == clsJr);
			end
			stWriteRd: begin
				RegDst = regDstRd;
				RegWrite = 1'b1;
			end
			stWriteImm: RegWrite = 1'b1;
			stWriteSlt: begin
				RegDst = regDstRd;
				RegWrite = 1'b1;
				MemToReg = memToRegLt;
			end
			stCompare: begin
				ALUSrcA = srcARegA;
				ALUOp = aluCmp;
			end
			stBranch, stJump, stWriteCause: begin
				PCSource = pcSrcTarget;
				PCWrite = 1'b1;
			end
			stJalLink: MemToReg = memToRegPc;
			stJalWait2: WriteMDR = 1'b1;
			stJalWriteRa: begin
				RegDst = regDstRa;
				RegWrite = 1'b1;
				MemToReg = memToRegPc;
			end
			stBreak: begin
				ALUSrcB = srcBFour;
				ALUOp = aluSub; // back to the break itself
				PCWrite = 1'b1;
			end
			stRte: begin
				PCSource = pcSrcEpc;
				PCWrite = 1'b1;
			end
			stOvfExc: begin
				ALUSrcB = srcBFour;
				ALUOp = aluSub;
				WriteALUOut = 1'b1;
				EPCWrite = 1'b1; // faulting PC
			end
			stCause: begin
				SrcAddressMem = srcAddrCause;
				WriteMDR = 1'b1;
				ALUSrcA = srcACause;
				WriteALUOut = 1'b1;
			end
			default: ; // Wait and JalWait1 hold everything low
		endcase
	end

endmodule

`default_nettype wire

// File: controlUnit.f
ctrlPkg.sv
instrInfoIf.sv
instrDecoder.sv
branchEval.sv
controlSequencer.sv
controlUnit.sv
tbClock.sv
tbControlUnit.sv

// File: controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit
	import ctrlPkg::*;
	(
	input wire logic clk,
	input wire logic reset,
	input wire logic [opWidth-1:0] OpCode,
	input wire logic [opWidth-1:0] Func,
	input wire logic Overflow,
	input wire logic EQ,
	input wire logic GT,
	output logic [srcAddrWidth-1:0] SrcAddressMem,
	output logic MemOp,
	output logic WriteMDR,
	output logic IRWrite,
	output logic [regDstWidth-1:0] RegDst,
	output logic RegWrite,
	output logic WriteA,
	output logic WriteB,
	output logic [aluSrcAWidth-1:0] ALUSrcA,
	output logic [aluSrcBWidth-1:0] ALUSrcB,
	output logic [aluOpWidth-1:0] ALUOp,
	output logic WriteALUOut,
	output logic EPCWrite,
	output logic [pcSourceWidth-1:0] PCSource,
	output logic PCWrite,
	output logic [memToRegWidth-1:0] MemToReg
);

	instrInfoIf info ();

	instrDecoder decoder (
		.OpCode(OpCode),
		.Func(Func),
		.info(info.decoder)
	);

	branchEval evaluator (
		.EQ(EQ),
		.GT(GT),
		.info(info.evaluator)
	);

	controlSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.Overflow(Overflow),
		.info(info.sequencer),
		.SrcAddressMem(SrcAddressMem),
		.MemOp(MemOp),
		.WriteMDR(WriteMDR),
		.IRWrite(IRWrite),
		.RegDst(RegDst),
		.RegWrite(RegWrite),
		.WriteA(WriteA),
		.WriteB(WriteB),
		.ALUSrcA(ALUSrcA),
		.ALUSrcB(ALUSrcB),
		.ALUOp(ALUOp),
		.WriteALUOut(WriteALUOut),
		.EPCWrite(EPCWrite),
		.PCSource(PCSource),
		.PCWrite(PCWrite),
		.MemToReg(MemToReg)
	);

endmodule

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	localparam int opWidth = 6;
	localparam int stateWidth = 5;
	localparam int classWidth = 4;
	localparam int kindWidth = 2;

	// control word field widths
	localparam int srcAddrWidth = 3;
	localparam int regDstWidth = 3;
	localparam int aluSrcAWidth = 2;
	localparam int aluSrcBWidth = 3;
	localparam int aluOpWidth = 3;
	localparam int pcSourceWidth = 2;
	localparam int memToRegWidth = 3;

	// primary opcodes
	localparam logic [opWidth-1:0] opTypeR = 6'h00;
	localparam logic [opWidth-1:0] opBlm = 6'h01;
	localparam logic [opWidth-1:0] opJ = 6'h02;
	localparam logic [opWidth-1:0] opJal = 6'h03;
	localparam logic [opWidth-1:0] opBeq = 6'h04;
	localparam logic [opWidth-1:0] opBne = 6'h05;
	localparam logic [opWidth-1:0] opBle = 6'h06;
	localparam logic [opWidth-1:0] opBgt = 6'h07;
	localparam logic [opWidth-1:0] opAddi = 6'h08;
	localparam logic [opWidth-1:0] opAddiu = 6'h09;

	// R-type function field
	localparam logic [opWidth-1:0] fnAdd = 6'h20;
	localparam logic [opWidth-1:0] fnSub = 6'h22;
	localparam logic [opWidth-1:0] fnAnd = 6'h24;
	localparam logic [opWidth-1:0] fnJr = 6'h08;
	localparam logic [opWidth-1:0] fnSlt = 6'h2A;
	localparam logic [opWidth-1:0] fnBreak = 6'h0D;
	localparam logic [opWidth-1:0] fnRte = 6'h13;

	// instruction classes
	localparam logic [classWidth-1:0] clsAluR = 4'd0; // add, sub, and
	localparam logic [classWidth-1:0] clsAluImm = 4'd1; // addi, addiu
	localparam logic [classWidth-1:0] clsSlt = 4'd2;
	localparam logic [classWidth-1:0] clsJr = 4'd3;
	localparam logic [classWidth-1:0] clsJump = 4'd4;
	localparam logic [classWidth-1:0] clsJal = 4'd5;
	localparam logic [classWidth-1:0] clsBranch = 4'd6;
	localparam logic [classWidth-1:0] clsBreak = 4'd7;
	localparam logic [classWidth-1:0] clsRte = 4'd8;
	localparam logic [classWidth-1:0] clsIllegal = 4'd9;

	// conditional branch kinds
	localparam logic [kindWidth-1:0] kindBeq = 2'd0;
	localparam logic [kindWidth-1:0] kindBne = 2'd1;
	localparam logic [kindWidth-1:0] kindBle = 2'd2;
	localparam logic [kindWidth-1:0] kindBgt = 2'd3;

	// FSM states
	localparam logic [stateWidth-1:0] stReset = 5'd0;
	localparam logic [stateWidth-1:0] stFetch = 5'd1;
	localparam logic [stateWidth-1:0] stWait = 5'd2;
	localparam logic [stateWidth-1:0] stIrWrite = 5'd3;
	localparam logic [stateWidth-1:0] stDecode = 5'd4;
	localparam logic [stateWidth-1:0] stExecute = 5'd5;
	localparam logic [stateWidth-1:0] stWriteRd = 5'd6;
	localparam logic [stateWidth-1:0] stWriteImm = 5'd7;
	localparam logic [stateWidth-1:0] stWriteSlt = 5'd8;
	localparam logic [stateWidth-1:0] stCompare = 5'd9;
	localparam logic [stateWidth-1:0] stBranch = 5'd10;
	localparam logic [stateWidth-1:0] stJump = 5'd11;
	localparam logic [stateWidth-1:0] stJalLink = 5'd12;
	localparam logic [stateWidth-1:0] stJalWait1 = 5'd13;
	localparam logic [stateWidth-1:0] stJalWait2 = 5'd14;
	localparam logic [stateWidth-1:0] stJalWriteRa = 5'd15;
	localparam logic [stateWidth-1:0] stBreak = 5'd16;
	localparam logic [stateWidth-1:0] stRte = 5'd17;
	localparam logic [stateWidth-1:0] stOvfExc = 5'd18;
	localparam logic [stateWidth-1:0] stCause = 5'd19;
	localparam logic [stateWidth-1:0] stWriteCause = 5'd20;

	// ALU operations
	localparam logic [aluOpWidth-1:0] aluPass = 3'd0;
	localparam logic [aluOpWidth-1:0] aluAdd = 3'd1;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
	localparam logic [aluOpWidth-1:0] aluCmp = 3'd7;

	// ALU B operand select
	localparam logic [aluSrcBWidth-1:0] srcBReg = 3'd0;
	localparam logic [aluSrcBWidth-1:0] srcBFour = 3'd1;
	localparam logic [aluSrcBWidth-1:0] srcBSignImm = 3'd2;
	localparam logic [aluSrcBWidth-1:0] srcBShiftImm = 3'd3;
	localparam logic [aluSrcBWidth-1:0] srcBZeroImm = 3'd4;

	// remaining mux selects
	localparam logic [aluSrcAWidth-1:0] srcARegA = 2'd1;
	localparam logic [aluSrcAWidth-1:0] srcACause = 2'd3;
	localparam logic [regDstWidth-1:0] regDstRd = 3'd1;
	localparam logic [regDstWidth-1:0] regDstRa = 3'd2;
	localparam logic [regDstWidth-1:0] regDstSp = 3'd3;
	localparam logic [memToRegWidth-1:0] memToRegPc = 3'd1;
	localparam logic [memToRegWidth-1:0] memToRegLt = 3'd6;
	localparam logic [memToRegWidth-1:0] memToRegSpInit = 3'd7;
	localparam logic [pcSourceWidth-1:0] pcSrcTarget = 2'd1;
	localparam logic [pcSourceWidth-1:0] pcSrcEpc = 2'd3;
	localparam logic [srcAddrWidth-1:0] srcAddrCause = 3'd3;

endpackage

`default_nettype wire

// File: instrDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecoder
	import ctrlPkg::*;
	(
	input wire logic [opWidth-1:0] OpCode,
	input wire logic [opWidth-1:0] Func,
	instrInfoIf.decoder info
);

	always_comb begin
		info.instrClass = clsIllegal;
		info.branchKind = kindBeq;
		info.execAluOp = aluPass;
		info.execAluSrcB = srcBReg;

		case (OpCode)
			opTypeR: begin
				case (Func)
					fnAdd: begin
						info.instrClass = clsAluR;
						info.execAluOp = aluAdd;
					end
					fnSub: begin
						info.instrClass = clsAluR;
						info.execAluOp = aluSub;
					end
					fnAnd: begin
						info.instrClass = clsAluR;
						info.execAluOp = aluAnd;
					end
					fnSlt: begin
						info.instrClass = clsSlt;
						info.execAluOp = aluCmp;
					end
					fnJr: info.instrClass = clsJr; // A passes straight to PC
					fnBreak: info.instrClass = clsBreak;
					fnRte: info.instrClass = clsRte;
					default: info.instrClass = clsIllegal;
				endcase
			end
			opAddi: begin
				info.instrClass = clsAluImm;
				info.execAluOp = aluAdd;
				info.execAluSrcB = srcBSignImm;
			end
			opAddiu: begin
				info.instrClass = clsAluImm;
				info.execAluOp = aluAdd;
				info.execAluSrcB = srcBZeroImm; // no sign extension
			end
			opJ: info.instrClass = clsJump;
			opJal: info.instrClass = clsJal;
			opBeq: begin
				info.instrClass = clsBranch;
				info.branchKind = kindBeq;
			end
			opBne: begin
				info.instrClass = clsBranch;
				info.branchKind = kindBne;
			end
			opBle: begin
				info.instrClass = clsBranch;
				info.branchKind = kindBle;
			end
			opBgt: begin
				info.instrClass = clsBranch;
				info.branchKind = kindBgt;
			end
			default: info.instrClass = clsIllegal;
		endcase
	end

endmodule

`default_nettype wire

// File: instrInfoIf.sv
`timescale 1ns/100ps
`default_nettype none

interface instrInfoIf
	import ctrlPkg::*;
	();

	logic [classWidth-1:0] instrClass;
	logic [kindWidth-1:0] branchKind;
	logic [aluOpWidth-1:0] execAluOp;
	logic [aluSrcBWidth-1:0] execAluSrcB;
	logic branchTaken;

	modport decoder (output instrClass, output branchKind, output execAluOp,
		output execAluSrcB);

	modport evaluator (input branchKind, output branchTaken);

	modport sequencer (input instrClass, input branchKind, input execAluOp,
		input execAluSrcB, input branchTaken);

endinterface

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk; // 20 ns period
	end

endmodule

`default_nettype wire

// File: tbControlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tbControlUnit
	import ctrlPkg::*;
	();

	logic clk;
	logic reset;
	logic [opWidth-1:0] OpCode;
	logic [opWidth-1:0] Func;
	logic Overflow;
	logic EQ;
	logic GT;
	logic [2:0] SrcAddressMem, RegDst, ALUSrcB, ALUOp, MemToReg;
	logic [1:0] ALUSrcA, PCSource;
	logic MemOp, WriteMDR, IRWrite, RegWrite, WriteA, WriteB, WriteALUOut, EPCWrite, PCWrite;

	logic [stateWidth-1:0] mState = stReset; // model of the FSM state
	logic [classWidth-1:0] mClass;
	logic [aluOpWidth-1:0] mAluOp;
	logic [aluSrcBWidth-1:0] mSrcB;
	integer expW [16];
	integer actW [16];
	int visits [21];
	int lo = 0;
	int hi = 14;
	int randomShare = 10; // one draw in this many is a raw random code
	int errors, checks, decodes, ovfTraps, branchesTaken;
	string fieldName [16] = '{"SrcAddressMem", "MemOp", "WriteMDR", "IRWrite", "RegDst",
		"RegWrite", "WriteA", "WriteB", "ALUSrcA", "ALUSrcB", "ALUOp", "WriteALUOut",
		"EPCWrite", "PCSource", "PCWrite", "MemToReg"};
	// {opcode, function} pairs, ALU 0-5, branches 6-9, jumps and the rest 10-14
	logic [11:0] pool [15] = '{{opTypeR, fnAdd}, {opTypeR, fnSub}, {opTypeR, fnAnd},
		{opTypeR, fnSlt}, {opAddi, 6'h00}, {opAddiu, 6'h00}, {opBeq, 6'h00}, {opBne, 6'h00},
		{opBle, 6'h00}, {opBgt, 6'h00}, {opJ, 6'h00}, {opJal, 6'h00}, {opTypeR, fnJr},
		{opTypeR, fnBreak}, {opTypeR, fnRte}};

	tbClock clockGen (.clk(clk));

	controlUnit UUT (.*);

	task automatic setWord(input int addr, memOp, mdr, ir, regDst, regWr, wa, wb, srcA, srcB,
		op, aluOut, epc, pcSrc, pcWr, memToReg);
		expW = '{addr, memOp, mdr, ir, regDst, regWr, wa, wb, srcA, srcB, op, aluOut, epc,
			pcSrc, pcWr, memToReg};
	endtask

	// field order follows fieldName
	task automatic expectWord(input logic [stateWidth-1:0] s);
		case (s)
			stReset: setWord(0, 0, 0, 0, 3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 7);
			stFetch: setWord(0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1, 0);
			stIrWrite: setWord(0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
			stDecode: setWord(0, 0, 0, 0, 0, 0, 1, 1, 0, 3, 1, 1, 0, 0, 0, 0);
			stExecute: setWord(0, 0, 0, 0, 0, 0, 0, 0, 1, mSrcB, mAluOp, 1, 0, 0,
				mClass == clsJr, 0);
			stWriteRd: setWord(0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
			stWriteImm: setWord(0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
			stWriteSlt: setWord(0, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 6);
			stCompare: setWord(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 7, 0, 0, 0, 0, 0);
			stBranch, stJump, stWriteCause: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
			stJalLink: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
			stJalWait2: setWord(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
			stJalWriteRa: setWord(0, 0, 0, 0, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
			stBreak: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 0, 0, 0, 1, 0);
			stRte: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3, 1, 0);
			stOvfExc: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 1, 1, 0, 0, 0);
			stCause: setWord(3, 0, 1, 0, 0, 0, 0, 0, 3, 0, 0, 1, 0, 0, 0, 0);
			default: setWord(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		endcase
	endtask

	task automatic decodeModel(input logic [opWidth-1:0] op, fn);
		{mClass, mAluOp, mSrcB} = {clsIllegal, aluPass, srcBReg};
		case (op)
			opTypeR:
				case (fn)
					fnAdd: {mClass, mAluOp} = {clsAluR, aluAdd};
					fnSub: {mClass, mAluOp} = {clsAluR, aluSub};
					fnAnd: {mClass, mAluOp} = {clsAluR, aluAnd};
					fnSlt: {mClass, mAluOp} = {clsSlt, aluCmp};
					fnJr: mClass = clsJr;
					fnBreak: mClass = clsBreak;
					fnRte: mClass = clsRte;
				endcase
			opAddi: {mClass, mAluOp, mSrcB} = {clsAluImm, aluAdd, srcBSignImm};
			opAddiu: {mClass, mAluOp, mSrcB} = {clsAluImm, aluAdd, srcBZeroImm};
			opJ: mClass = clsJump;
			opJal: mClass = clsJal;
			opBeq, opBne, opBle, opBgt: mClass = clsBranch;
		endcase
	endtask

	task automatic runTest(input string name, input int first, last, share, cycles);
		int startErrors;
		int startDecodes;
		startErrors = errors;
		startDecodes = decodes;
		lo = first;
		hi = last;
		randomShare = share;
		repeat (cycles) @(negedge clk);
		$display("test %s done, %0d instructions, %0d errors", name, decodes - startDecodes,
			errors - startErrors);
	endtask

	task automatic stepModel();
		if (reset) begin
			mState = stReset;
		end else begin
			case (mState)
				stFetch: mState = stWait;
				stWait: mState = stIrWrite;
				stIrWrite: mState = stDecode;
				stDecode: begin
					decodeModel(OpCode, Func);
					decodes++;
					case (mClass)
						clsAluR, clsAluImm, clsSlt, clsJr: mState = stExecute;
						clsJump: mState = stJump;
						clsJal: mState = stJalLink;
						clsBranch: mState = stCompare;
						clsBreak: mState = stBreak;
						clsRte: mState = stRte;
						default: mState = stFetch;
					endcase
				end
				stExecute: begin
					case (mClass)
						clsAluR: mState = stWriteRd;
						clsAluImm: mState = stWriteImm;
						clsSlt: mState = stWriteSlt;
						default: mState = stFetch; // jr
					endcase
					if (Overflow && (mClass == clsAluImm ||
						(mClass == clsAluR && mAluOp != aluAnd))) begin
						mState = stOvfExc;
						ovfTraps++;
					end
				end
				stCompare: begin
					mState = stFetch;
					if ((OpCode == opBeq && EQ) || (OpCode == opBne && !EQ) ||
						(OpCode == opBle && !GT) || (OpCode == opBgt && GT)) begin
						mState = stBranch;
						branchesTaken++;
					end
				end
				stJalLink: mState = stJalWait1;
				stJalWait1: mState = stJalWait2;
				stJalWait2: mState = stJalWriteRa;
				stJalWriteRa: mState = stJump;
				stOvfExc: mState = stCause;
				stCause: mState = stWriteCause;
				default: mState = stFetch;
			endcase
		end
		visits[mState]++;
	endtask

	// opcode held into Compare, so the branch kind there is the decoded one
	task automatic driveInputs();
		int pick;
		if (mState != stCompare) begin
			pick = $urandom_range(lo, hi);
			OpCode <= pool[pick][11:6];
			Func <= pool[pick][5:0];
			if ($urandom_range(1, randomShare) == 1) begin
				OpCode <= 6'($urandom);
				Func <= 6'($urandom);
			end
		end
		Overflow <= 1'($urandom);
		EQ <= 1'($urandom);
		GT <= 1'($urandom);
	endtask

	task automatic checkOutputs();
		expectWord(mState);
		actW = '{SrcAddressMem, MemOp, WriteMDR, IRWrite, RegDst, RegWrite, WriteA, WriteB,
			ALUSrcA, ALUSrcB, ALUOp, WriteALUOut, EPCWrite, PCSource, PCWrite, MemToReg};
		checks++;
		for (int i = 0; i < 16; i++) begin
			if (actW[i] !== expW[i]) begin
				$display("ERR %s expected %0h got %0h in state %0d", fieldName[i], expW[i],
					actW[i], mState);
				errors++;
			end
		end
	endtask

	// model step and new inputs on the rising edge, outputs checked on the falling edge
	initial begin
		void'($urandom(51));
		forever begin
			@(posedge clk);
			stepModel();
			driveInputs();
			@(negedge clk);
			checkOutputs();
		end
	end

	initial begin
		int missing;
		reset = 1'b1;
		OpCode = opTypeR;
		Func = fnAdd;
		Overflow = 1'b0;
		EQ = 1'b0;
		GT = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// Fetch is the only word with both WriteMDR and PCWrite
		for (int n = 0; n < 4 && !(WriteMDR === 1'b1 && PCWrite === 1'b1); n++)
			@(negedge clk);
		if (WriteMDR !== 1'b1 || PCWrite !== 1'b1) begin
			$display("timeout: the DUT did not reach Fetch after reset");
			errors++;
		end
		$display("test reset done, %0d errors", errors);
		runTest("fetch", 0, 14, 10, 2000);
		runTest("alu", 0, 5, 20, 3000);
		runTest("branch", 6, 9, 20, 3000);
		runTest("jump", 10, 14, 20, 3000);
		runTest("illegal", 0, 14, 2, 3000);
		missing = 0;
		for (int s = 0; s < 21; s++) begin
			if (visits[s] == 0) begin
				$display("state %0d was never reached", s);
				missing++;
			end
		end
		errors += missing;
		$display("test coverage done, %0d states missed, %0d overflow traps, %0d branches taken",
			missing, ovfTraps, branchesTaken);
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
